// File: src/core_pkg.sv
`default_nettype none

package core_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int sel_w      = 4;  // one select bit per byte lane

  localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

  // base opcodes of the supported subset
  localparam logic [6:0] op_opimm  = 7'b001_0011;
  localparam logic [6:0] op_lui    = 7'b011_0111;
  localparam logic [6:0] op_auipc  = 7'b001_0111;
  localparam logic [6:0] op_jal    = 7'b110_1111;
  localparam logic [6:0] op_jalr   = 7'b110_0111;
  localparam logic [6:0] op_load   = 7'b000_0011;
  localparam logic [6:0] op_store  = 7'b010_0011;
  localparam logic [6:0] op_system = 7'b111_0011;

  localparam logic [2:0] f3_addi = 3'b000;

  // memory width and signedness
  localparam logic [2:0] f3_b  = 3'b000;
  localparam logic [2:0] f3_h  = 3'b001;
  localparam logic [2:0] f3_w  = 3'b010;
  localparam logic [2:0] f3_bu = 3'b100;
  localparam logic [2:0] f3_hu = 3'b101;

  // first adder operand
  localparam logic [1:0] op1_rs1  = 2'd0;
  localparam logic [1:0] op1_pc   = 2'd1;
  localparam logic [1:0] op1_zero = 2'd2;

  typedef struct packed {
    logic [11:0]           imm;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]            imm_hi;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm_lo;
    logic [6:0]            opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0]           imm;
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } u_fmt_t;

  typedef struct packed {
    logic                  imm_20;
    logic [9:0]            imm_10_1;
    logic                  imm_11;
    logic [7:0]            imm_19_12;
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } j_fmt_t;

  // one instruction word, four ways to read it
  typedef union packed {
    i_fmt_t i;
    s_fmt_t s;
    u_fmt_t u;
    j_fmt_t j;
  } inst_word_u;

endpackage

`default_nettype wire

// File: src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
  import core_pkg::*;
(
  input  wire                   clk,
  input  wire                   wen,
  input  wire  [reg_addr_w-1:0] waddr,
  input  wire  [xlen-1:0]       wdata,
  input  wire  [reg_addr_w-1:0] rs1_addr,
  input  wire  [reg_addr_w-1:0] rs2_addr,
  output logic [xlen-1:0]       rs1_data,
  output logic [xlen-1:0]       rs2_data
);

  logic [xlen-1:0] regs [1 << reg_addr_w];

  // x0 is never stored, the read mux supplies the zero
  always_ff @(posedge clk) begin
    if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  always_comb begin
    if (rs1_addr == '0) begin
      rs1_data = '0;
    end else begin
      rs1_data = regs[rs1_addr];
    end
  end

  always_comb begin
    if (rs2_addr == '0) begin
      rs2_data = '0;
    end else begin
      rs2_data = regs[rs2_addr];
    end
  end

endmodule

`default_nettype wire

// File: src/inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decode
  import core_pkg::*;
(
  input  wire  [xlen-1:0]       inst,
  output logic [reg_addr_w-1:0] rs1,
  output logic [reg_addr_w-1:0] rs2,
  output logic [reg_addr_w-1:0] rd,
  output logic [2:0]            funct3,
  output logic [1:0]            op1_sel,
  output logic [xlen-1:0]       imm,
  output logic                  reg_wen,
  output logic                  mem_read,
  output logic                  mem_write,
  output logic                  is_jump,
  output logic                  is_jalr,
  output logic                  is_system
);

  inst_word_u iw;

  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;

  assign iw = inst;

  // register fields sit at the same place in every format
  assign rs1    = iw.i.rs1;
  assign rs2    = iw.s.rs2;
  assign rd     = iw.i.rd;
  assign funct3 = iw.i.funct3;

  assign imm_i = {{20{iw.i.imm[11]}}, iw.i.imm};
  assign imm_s = {{20{iw.s.imm_hi[6]}}, iw.s.imm_hi, iw.s.imm_lo};
  assign imm_u = {iw.u.imm, 12'h000};  // already in the upper bits
  // jal offset bits come scrambled
  assign imm_j = {{11{iw.j.imm_20}}, iw.j.imm_20, iw.j.imm_19_12,
                  iw.j.imm_11, iw.j.imm_10_1, 1'b0};

  always_comb begin
    op1_sel   = op1_zero;
    imm       = '0;
    reg_wen   = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    is_jump   = 1'b0;
    is_jalr   = 1'b0;
    is_system = 1'b0;
    case (iw.i.opcode)
      op_opimm: begin
        // only addi, other immediate ALU ops fall through as no-ops
        if (iw.i.funct3 == f3_addi) begin
          op1_sel = op1_rs1;
          imm     = imm_i;
          reg_wen = 1'b1;
        end
      end
      op_lui: begin
        op1_sel = op1_zero;  // 0 + imm
        imm     = imm_u;
        reg_wen = 1'b1;
      end
      op_auipc: begin
        op1_sel = op1_pc;
        imm     = imm_u;
        reg_wen = 1'b1;
      end
      op_jal: begin
        op1_sel = op1_pc;
        imm     = imm_j;
        reg_wen = 1'b1;
        is_jump = 1'b1;
      end
      op_jalr: begin
        op1_sel = op1_rs1;
        imm     = imm_i;
        reg_wen = 1'b1;
        is_jump = 1'b1;
        is_jalr = 1'b1;
      end
      op_load: begin
        op1_sel  = op1_rs1;
        imm      = imm_i;
        reg_wen  = 1'b1;
        mem_read = 1'b1;
      end
      op_store: begin
        op1_sel   = op1_rs1;
        imm       = imm_s;
        mem_write = 1'b1;
      end
      op_system: is_system = 1'b1;  // ebreak
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: src/lsu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu
  import core_pkg::*;
(
  input  wire                   clk,
  input  wire                   reset,
  input  wire  [xlen-1:0]       addr,
  input  wire  [xlen-1:0]       store_data,
  input  wire  [2:0]            funct3,
  input  wire                   mem_read,
  input  wire                   mem_write,
  output logic [xlen-1:0]       load_data,
  output logic                  mem_done,
  output logic                  wb_cyc,
  output logic                  wb_stb,
  output logic                  wb_we,
  output logic [xlen-1:0]       wb_adr,
  output logic [xlen-1:0]       wb_dat_w,
  output logic [sel_w-1:0]      wb_sel,
  input  wire  [xlen-1:0]       wb_dat_r,
  input  wire                   wb_ack
);

  logic             ack_seen;  // high in the cycle after ack
  logic             req;
  logic [1:0]       offset;
  logic [sel_w-1:0] byte_mask;
  logic [7:0]       ld_byte;
  logic [15:0]      ld_half;

  assign req    = mem_read | mem_write;
  assign offset = addr[1:0];

  // the cycle opens as soon as the instruction shows up
  assign wb_cyc   = req & ~ack_seen;
  assign wb_stb   = wb_cyc;
  assign wb_we    = wb_cyc & mem_write;
  assign wb_adr   = addr;
  assign wb_sel   = wb_cyc ? byte_mask : '0;
  assign mem_done = wb_cyc & wb_ack;

  always_ff @(posedge clk) begin
    if (reset) begin
      ack_seen <= 1'b0;
    end else begin
      ack_seen <= mem_done;  // clears itself since cyc is low meanwhile
    end
  end

  always_comb begin
    case (funct3)
      f3_b, f3_bu: begin
        byte_mask = 4'b0001 << offset;
        wb_dat_w  = {4{store_data[7:0]}};
      end
      f3_h, f3_hu: begin
        byte_mask = 4'b0011 << {offset[1], 1'b0};
        wb_dat_w  = {2{store_data[15:0]}};
      end
      default: begin
        byte_mask = 4'b1111;
        wb_dat_w  = store_data;
      end
    endcase
  end

  always_comb begin
    case (offset)
      2'd0:    ld_byte = wb_dat_r[7:0];
      2'd1:    ld_byte = wb_dat_r[15:8];
      2'd2:    ld_byte = wb_dat_r[23:16];
      default: ld_byte = wb_dat_r[31:24];
    endcase
  end

  assign ld_half = offset[1] ? wb_dat_r[31:16] : wb_dat_r[15:0];

  always_comb begin
    case (funct3)
      f3_b:    load_data = {{24{ld_byte[7]}}, ld_byte};
      f3_h:    load_data = {{16{ld_half[15]}}, ld_half};
      f3_w:    load_data = wb_dat_r;
      f3_bu:   load_data = {24'h00_0000, ld_byte};
      f3_hu:   load_data = {16'h0000, ld_half};
      default: load_data = '0;  // reserved widths read as zero
    endcase
  end

  // request held steady until the slave answers
  a_req_stable: assert property (@(posedge clk) disable iff (reset)
    (wb_cyc && !wb_ack) |=> (wb_cyc && $stable(wb_adr) && $stable(wb_we) && $stable(wb_sel)));

  a_ack_in_cyc: assert property (@(posedge clk) disable iff (reset)
    wb_ack |-> wb_cyc);

endmodule

`default_nettype wire

// File: src/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core
  import core_pkg::*;
(
  input  wire              clk,
  input  wire              reset,
  input  wire  [xlen-1:0]  inst,
  output logic [xlen-1:0]  pc,
  output logic             halt,
  output logic             wb_cyc,
  output logic             wb_stb,
  output logic             wb_we,
  output logic [xlen-1:0]  wb_adr,
  output logic [xlen-1:0]  wb_dat_w,
  output logic [sel_w-1:0] wb_sel,
  input  wire  [xlen-1:0]  wb_dat_r,
  input  wire              wb_ack
);

  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [reg_addr_w-1:0] rd;
  logic [2:0]            funct3;
  logic [1:0]            op1_sel;
  logic [xlen-1:0]       imm;
  logic                  reg_wen;
  logic                  mem_read;
  logic                  mem_write;
  logic                  is_jump;
  logic                  is_jalr;
  logic                  is_system;

  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] load_data;
  logic            mem_done;

  logic [xlen-1:0] op1;
  logic [xlen-1:0] sum;       // the one adder
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] next_pc;
  logic [xlen-1:0] wdata;
  logic            stall;
  logic            reg_we;

  inst_decode u_decode (
    .inst      (inst),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .funct3    (funct3),
    .op1_sel   (op1_sel),
    .imm       (imm),
    .reg_wen   (reg_wen),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .is_jump   (is_jump),
    .is_jalr   (is_jalr),
    .is_system (is_system)
  );

  reg_file u_regs (
    .clk      (clk),
    .wen      (reg_we),
    .waddr    (rd),
    .wdata    (wdata),
    .rs1_addr (rs1),
    .rs2_addr (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  lsu u_lsu (
    .clk        (clk),
    .reset      (reset),
    .addr       (sum),
    .store_data (rs2_data),
    .funct3     (funct3),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .load_data  (load_data),
    .mem_done   (mem_done),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_sel     (wb_sel),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack)
  );

  always_comb begin
    case (op1_sel)
      op1_rs1: op1 = rs1_data;
      op1_pc:  op1 = pc;
      default: op1 = '0;
    endcase
  end

  assign sum      = op1 + imm;
  assign pc_plus4 = pc + 32'd4;

  // jalr drops bit 0 of the target
  assign next_pc = !is_jump ? pc_plus4 :
                   is_jalr  ? {sum[xlen-1:1], 1'b0} : sum;

  assign wdata = is_jump  ? pc_plus4  :
                 mem_read ? load_data : sum;

  assign stall  = (mem_read | mem_write) & ~mem_done;
  assign halt   = is_system;  // ebreak stays presented, so this holds
  assign reg_we = reg_wen & ~stall & ~halt;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= reset_pc;
    end else if (!stall && !halt) begin
      pc <= next_pc;
    end
  end

  // instruction retires only on the ack edge
  a_pc_hold: assert property (@(posedge clk) disable iff (reset)
    (wb_cyc && !wb_ack) |=> $stable(pc));

endmodule

`default_nettype wire

// File: bench/core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module core_checker
  import core_pkg::*;
(
  input wire             clk,
  input wire             reset,
  input wire [xlen-1:0]  pc,
  input wire             halt,
  input wire             wb_cyc,
  input wire             wb_stb,
  input wire             wb_we,
  input wire [xlen-1:0]  wb_adr,
  input wire [xlen-1:0]  wb_dat_w,
  input wire [sel_w-1:0] wb_sel,
  input wire             wb_ack
);

  int errors = 0;

  // expected retire and bus sequences, filled by the model
  logic [xlen-1:0]  exp_pc [$];
  logic             exp_we [$];
  logic [xlen-1:0]  exp_adr [$];
  logic [sel_w-1:0] exp_sel [$];
  logic [xlen-1:0]  exp_dat [$];

  logic [xlen-1:0]  last_pc;
  logic [xlen-1:0]  hold_adr;
  logic [xlen-1:0]  hold_dat;
  logic [sel_w-1:0] hold_sel;
  logic             hold_we;
  logic             was_open = 1'b0;   // open and unacked at the last edge
  logic             was_acked = 1'b0;
  logic             reset_seen = 1'b0;

  task expect_pc(input logic [xlen-1:0] v);
    exp_pc.push_back(v);
  endtask

  task expect_bus(input logic we, input logic [xlen-1:0] adr, input logic [sel_w-1:0] sel,
                  input logic [xlen-1:0] dat);
    exp_we.push_back(we);
    exp_adr.push_back(adr);
    exp_sel.push_back(sel);
    exp_dat.push_back(dat);
  endtask

  function logic [xlen-1:0] lane_mask(input logic [sel_w-1:0] sel);
    return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
  endfunction

  task check_value(input string name, input logic [xlen-1:0] exp, input logic [xlen-1:0] got);
    if (exp !== got) begin
      errors++;
      $display("Error %s expected %h got %h", name, exp, got);
    end
  endtask

  task fail(input string what);
    errors++;
    $display("%s at %0t", what, $time);
  endtask

  task final_check();
    if (exp_pc.size() != 0) fail("model instructions never retired by the core");
    if (exp_we.size() != 0) fail("model bus cycles never seen on the bus");
  endtask

  always @(posedge clk) begin
    if (reset) begin
      if (reset_seen) begin
        check_value("pc", reset_pc, pc);
        if (wb_cyc || wb_stb || wb_we || halt) fail("bus or halt active during reset");
      end
      reset_seen = 1'b1;
      was_open   = 1'b0;
      was_acked  = 1'b0;
    end else begin
      if (wb_stb !== wb_cyc) fail("wb_stb and wb_cyc differ");
      if (halt && wb_cyc) fail("bus cycle while halted");
      if (was_open) begin
        if (!wb_cyc) begin
          fail("bus cycle dropped before ack");
        end else begin
          check_value("wb_adr", hold_adr, wb_adr);
          check_value("wb_we", 32'(hold_we), 32'(wb_we));
          check_value("wb_sel", 32'(hold_sel), 32'(wb_sel));
          check_value("wb_dat_w", hold_dat, wb_dat_w);
        end
        if (pc !== last_pc) fail("pc moved while bus cycle unacknowledged");
      end
      if (was_acked && wb_cyc) fail("bus cycle did not drop after ack");
      if (pc !== last_pc && !was_open) begin
        if (exp_pc.size() == 0) fail("pc changed after the model program ended");
        else check_value("pc", exp_pc.pop_front(), pc);
      end
      if (wb_cyc && wb_ack) begin
        if (exp_we.size() == 0) begin
          fail("extra bus cycle");
        end else begin
          check_value("wb_we", 32'(exp_we.pop_front()), 32'(wb_we));
          check_value("wb_adr", exp_adr.pop_front(), wb_adr);
          if (wb_we) begin
            check_value("wb_sel", 32'(exp_sel[0]), 32'(wb_sel));
            check_value("wb_dat_w", exp_dat[0] & lane_mask(exp_sel[0]),
                        wb_dat_w & lane_mask(exp_sel[0]));
          end
          void'(exp_sel.pop_front());
          void'(exp_dat.pop_front());
        end
      end
      was_open  = wb_cyc && !wb_ack;
      was_acked = wb_cyc && wb_ack;
      hold_adr  = wb_adr;
      hold_dat  = wb_dat_w;
      hold_sel  = wb_sel;
      hold_we   = wb_we;
    end
    last_pc = pc;
  end

endmodule

`default_nettype wire

// File: bench/tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core
  import core_pkg::*;
();

  localparam int n_inst     = 200;
  localparam int max_cycles = n_inst * (1 + 4) + 50;
  localparam logic [31:0] data_base = 32'h0001_0000;

  logic clk = 1'b0;
  logic reset;
  logic [31:0] inst;
  logic [31:0] pc;
  logic halt;
  logic wb_cyc, wb_stb, wb_we, wb_ack;
  logic [31:0] wb_adr, wb_dat_w, wb_dat_r;
  logic [3:0] wb_sel;

  logic [31:0] imem [n_inst];
  logic [31:0] dmem [64];     // slave copy
  logic [31:0] mem_m [64];    // model copy
  logic [31:0] regs_m [32];
  bit no_jalr [n_inst];       // jump targets, never the jalr half of a pair
  logic [31:0] halt_pc;
  logic [31:0] lcg_state = 32'd55229;

  // slave state and edge samples
  logic bus_active = 1'b0;
  int wait_left = 0;
  logic s_reset, s_stb, s_we, s_ack;
  logic [31:0] s_adr, s_dat;
  logic [3:0] s_sel;

  always #20 clk = ~clk;

  rv_core uut (
    .clk(clk), .reset(reset), .inst(inst), .pc(pc), .halt(halt),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
  );

  core_checker chk (
    .clk(clk), .reset(reset), .pc(pc), .halt(halt), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
    .wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_ack(wb_ack)
  );

  function logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function int pick(input int n);  // 0 .. n-1
    logic [31:0] r;
    r = lcg_next();
    return int'(r[31:8] % 24'(n));
  endfunction

  function int pick_lane(input logic [2:0] f3);  // offset aligned to the access width
    if (f3 == f3_w) return 0;
    if (f3 == f3_h || f3 == f3_hu) return 2 * pick(2);
    return pick(4);
  endfunction

  function logic [5:0] didx(input logic [31:0] a);
    logic [31:0] d;
    d = a - data_base;
    return d[7:2];
  endfunction

  function logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3, input logic [4:0] rd,
                              input logic [4:0] rs1, input logic [11:0] imm);
    inst_word_u w;
    w = '0;
    w.i.opcode = op;
    w.i.funct3 = f3;
    w.i.rd     = rd;
    w.i.rs1    = rs1;
    w.i.imm    = imm;
    return w;
  endfunction

  function logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                              input logic [11:0] imm);
    inst_word_u w;
    w = '0;
    w.s.opcode = op_store;
    w.s.funct3 = f3;
    w.s.rs1    = rs1;
    w.s.rs2    = rs2;
    w.s.imm_hi = imm[11:5];
    w.s.imm_lo = imm[4:0];
    return w;
  endfunction

  function logic [31:0] enc_u(input logic [6:0] op, input logic [4:0] rd, input logic [19:0] imm);
    inst_word_u w;
    w = '0;
    w.u.opcode = op;
    w.u.rd     = rd;
    w.u.imm    = imm;
    return w;
  endfunction

  function logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
    inst_word_u w;
    w = '0;
    w.j.opcode    = op_jal;
    w.j.rd        = rd;
    w.j.imm_20    = off[20];
    w.j.imm_19_12 = off[19:12];
    w.j.imm_11    = off[11];
    w.j.imm_10_1  = off[10:1];
    return w;
  endfunction

  task automatic gen_program();
    int i;
    int k;
    int kind;
    int lane;
    logic [4:0] rd;
    logic [2:0] f3;
    for (i = 0; i < n_inst; i++) no_jalr[i] = 1'b0;
    for (i = 0; i < 64; i++) dmem[i] = lcg_next();
    imem[0] = enc_u(op_lui, 5'd10, data_base[31:12]);
    for (i = 1; i < 10; i++) imem[i] = enc_i(op_opimm, f3_addi, 5'(i), 5'd0, 12'(pick(4096)));
    i = 10;
    while (i < n_inst - 1) begin
      rd   = 5'(1 + pick(9));
      kind = pick(8);
      if (kind == 3 && i + 4 >= n_inst) kind = 0;
      if (kind == 4 && (i + 4 >= n_inst || no_jalr[i+1])) kind = 0;
      case (kind)
        0: imem[i] = enc_i(op_opimm, f3_addi, rd, 5'(pick(10)), 12'(pick(4096)));
        1: imem[i] = enc_u(op_lui, rd, 20'(pick(1 << 20)));
        2: imem[i] = enc_u(op_auipc, rd, 20'(pick(1 << 20)));
        3: begin
          k = 1 + pick(4);
          imem[i] = enc_j(rd, 21'(k * 4));
          no_jalr[i+k] = 1'b1;
        end
        4: begin
          k = pick(3);
          imem[i] = enc_u(op_auipc, 5'd11, 20'd0);
          // odd offsets check that bit 0 of the target is cleared
          imem[i+1] = enc_i(op_jalr, 3'b000, rd, 5'd11, 12'((2 + k) * 4 + pick(2)));
          no_jalr[i+2+k] = 1'b1;
          i++;
        end
        5: begin
          case (pick(5))
            0: f3 = f3_b;
            1: f3 = f3_bu;
            2: f3 = f3_h;
            3: f3 = f3_hu;
            default: f3 = f3_w;
          endcase
          lane = pick_lane(f3);
          imem[i] = enc_i(op_load, f3, rd, 5'd10, 12'(4 * pick(64) + lane));
        end
        default: begin
          case (pick(3))
            0: f3 = f3_b;
            1: f3 = f3_h;
            default: f3 = f3_w;
          endcase
          lane = pick_lane(f3);
          imem[i] = enc_s(f3, 5'd10, rd, 12'(4 * pick(64) + lane));
        end
      endcase
      i++;
    end
    imem[n_inst-1] = enc_i(op_system, 3'b000, 5'd0, 5'd0, 12'd1);  // ebreak
  endtask

  task automatic run_model();
    inst_word_u w;
    logic [31:0] mpc, npc, a, v, sh, d, dat, imm_i, imm_s, imm_u, imm_j;
    logic [3:0] sel;
    int steps;
    int off;
    int nbytes;
    mpc = reset_pc;
    for (int r = 0; r < 32; r++) regs_m[r] = '0;
    for (int m = 0; m < 64; m++) mem_m[m] = dmem[m];
    for (steps = 0; steps < 2 * n_inst; steps++) begin
      w = imem[int'((mpc - reset_pc) >> 2)];
      if (w.i.opcode == op_system) break;
      imm_i = {{20{w.i.imm[11]}}, w.i.imm};
      imm_s = {{20{w.s.imm_hi[6]}}, w.s.imm_hi, w.s.imm_lo};
      imm_u = {w.u.imm, 12'h000};
      imm_j = {{11{w.j.imm_20}}, w.j.imm_20, w.j.imm_19_12, w.j.imm_11, w.j.imm_10_1, 1'b0};
      npc = mpc + 32'd4;
      v   = '0;
      case (w.i.opcode)
        op_opimm: v = regs_m[w.i.rs1] + imm_i;
        op_lui:   v = imm_u;
        op_auipc: v = mpc + imm_u;
        op_jal: begin
          v   = mpc + 32'd4;
          npc = mpc + imm_j;
        end
        op_jalr: begin
          npc = (regs_m[w.i.rs1] + imm_i) & ~32'd1;
          v   = mpc + 32'd4;
        end
        op_load: begin
          a  = regs_m[w.i.rs1] + imm_i;
          sh = mem_m[didx(a)] >> {a[1:0], 3'b000};
          case (w.i.funct3)
            f3_b:    v = {{24{sh[7]}}, sh[7:0]};
            f3_bu:   v = {24'd0, sh[7:0]};
            f3_h:    v = {{16{sh[15]}}, sh[15:0]};
            f3_hu:   v = {16'd0, sh[15:0]};
            default: v = sh;
          endcase
          chk.expect_bus(1'b0, a, 4'h0, 32'h0);
        end
        default: begin
          a      = regs_m[w.s.rs1] + imm_s;
          d      = regs_m[w.s.rs2];
          off    = int'(a[1:0]);
          nbytes = (w.s.funct3 == f3_b) ? 1 : (w.s.funct3 == f3_h) ? 2 : 4;
          sel    = '0;
          dat    = '0;
          // value bytes land in the lanes from the offset upward
          for (int b = 0; b < 4; b++) begin
            if (b >= off && b < off + nbytes) begin
              sel[b]        = 1'b1;
              dat[8*b +: 8] = d[8*(b - off) +: 8];
              mem_m[didx(a)][8*b +: 8] = dat[8*b +: 8];
            end
          end
          chk.expect_bus(1'b1, a, sel, dat);
        end
      endcase
      if (w.i.opcode != op_store && w.i.rd != 5'd0) regs_m[w.i.rd] = v;
      chk.expect_pc(npc);
      mpc = npc;
    end
    halt_pc = mpc;
  endtask

  // data slave, registered ack with random wait states
  always @(posedge clk) begin
    s_reset = reset;
    s_stb   = wb_stb;
    s_we    = wb_we;
    s_adr   = wb_adr;
    s_sel   = wb_sel;
    s_dat   = wb_dat_w;
    s_ack   = wb_ack;
    #1;
    if (s_reset || s_ack || !s_stb) begin
      wb_ack     = 1'b0;
      bus_active = 1'b0;
    end else begin
      if (!bus_active) begin
        bus_active = 1'b1;
        wait_left  = pick(4);
      end
      if (wait_left == 0) begin
        for (int b = 0; b < 4; b++) begin
          if (s_we && s_sel[b]) dmem[didx(s_adr)][8*b +: 8] = s_dat[8*b +: 8];
        end
        wb_dat_r = dmem[didx(s_adr)];
        wb_ack   = 1'b1;
      end else begin
        wait_left--;
      end
    end
    if ((pc - reset_pc) >> 2 < n_inst) inst = imem[int'((pc - reset_pc) >> 2)];
    else inst = 32'h0000_0013;  // nop outside the program
  end

  initial begin
    int cycles;
    int tb_errors;
    tb_errors = 0;
    reset     = 1'b1;
    inst      = 32'h0000_0013;
    wb_ack    = 1'b0;
    wb_dat_r  = '0;
    gen_program();
    run_model();
    inst = imem[0];
    repeat (4) @(posedge clk);
    #1 reset = 1'b0;
    cycles = 0;
    while (!halt && cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    if (!halt) begin
      tb_errors++;
      $display("timeout, halt never rose within %0d cycles", max_cycles);
    end else begin
      if (pc !== halt_pc) begin
        tb_errors++;
        $display("Error pc expected %h got %h", halt_pc, pc);
      end
      repeat (5) begin
        @(posedge clk);
        if (pc !== halt_pc || !halt || wb_cyc) begin
          tb_errors++;
          $display("core did not stay frozen after halt");
        end
      end
    end
    chk.final_check();
    $display("errors: checker %0d, testbench %0d", chk.errors, tb_errors);
    if (chk.errors == 0 && tb_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
src/core_pkg.sv
src/reg_file.sv
src/inst_decode.sv
src/lsu.sv
src/rv_core.sv
bench/core_checker.sv
bench/tb_core.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_core
FILELIST  = verilog.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST OK"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
